// ==== src.f ====
+incdir+tb
common/div_types_pkg.sv
common/div_instr_pkg.sv
idiv/idiv_lane.sv
logic/lane_merge.sv
idiv/idiv_simd.sv
tb/tb_idiv_simd.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_idiv_simd -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
fi

echo "Pass message not found in sim.log"
exit 1

// ==== tb/div_model.svh ====
// Divider reference model
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

// Lane width in bits for each precision, the spare code is one wide lane
function automatic int lane_width(input div_types_pkg::prec_e p);
	case (p)
		div_types_pkg::WYDE: return 16;
		div_types_pkg::TETRA: return 32;
		default: return 64;
	endcase
endfunction

function automatic logic [63:0] lane_mask(input int w);
	if (w == 64)
		return '1;
	return (64'd1 << w) - 64'd1;
endfunction

// One lane of division, taken from the low w bits of a and b
// Signed results truncate toward zero and the remainder keeps the dividend sign
function automatic logic [63:0] lane_divide(input logic [63:0] a, input logic [63:0] b,
		input int w, input logic sgn, input logic rem);
	logic [63:0] m;
	logic [63:0] am;
	logic [63:0] bm;
	logic na;
	logic nb;
	logic [63:0] ma;
	logic [63:0] mb;
	logic [63:0] q;
	logic [63:0] r;
	m = lane_mask(w);
	am = a & m;
	bm = b & m;
	na = sgn & am[w-1];
	nb = sgn & bm[w-1];
	ma = na ? ((~am + 64'd1) & m) : am;
	mb = nb ? ((~bm + 64'd1) & m) : bm;
	if (mb == 64'd0) begin
		// Zero divisor gives an all ones quotient and hands back the dividend
		q = m;
		r = am;
	end else begin
		q = ma / mb;
		r = ma % mb;
		if (na ^ nb)
			q = (~q + 64'd1) & m;
		if (na)
			r = (~r + 64'd1) & m;
	end
	return rem ? r : q;
endfunction

// Whole word of lane results for the given precision
function automatic logic [63:0] word_result(input logic [63:0] a, input logic [63:0] b,
		input div_types_pkg::prec_e prc, input logic sgn, input logic rem);
	int w;
	logic [63:0] res;
	w = lane_width(prc);
	res = '0;
	for (int s = 0; s < 64; s += w)
		res = res | (lane_divide(a >> s, b >> s, w, sgn, rem) << s);
	return res;
endfunction

// Divide by zero code in the low byte of every lane whose divisor is zero
function automatic logic [63:0] word_faults(input logic [63:0] b,
		input div_types_pkg::prec_e prc);
	int w;
	logic [63:0] flt;
	w = lane_width(prc);
	flt = '0;
	for (int s = 0; s < 64; s += w)
		if (((b >> s) & lane_mask(w)) == 64'd0)
			flt = flt | ({56'd0, div_types_pkg::FLT_DBZ} << s);
	return flt;
endfunction

function automatic logic [63:0] merge_word(input logic [63:0] res, input logic [63:0] t,
		input logic [7:0] cp, input logic z, input logic nop);
	logic [63:0] o;
	for (int i = 0; i < 8; i++) begin
		if (nop)
			o[i*8 +: 8] = t[i*8 +: 8];
		else if (cp[i])
			o[i*8 +: 8] = z ? 8'h00 : t[i*8 +: 8];
		else
			o[i*8 +: 8] = res[i*8 +: 8];
	end
	return o;
endfunction

function automatic logic [63:0] merge_faults(input logic [63:0] flt, input logic [7:0] cp,
		input logic nop);
	logic [63:0] e;
	for (int i = 0; i < 8; i++)
		e[i*8 +: 8] = (nop || cp[i]) ? div_types_pkg::FLT_NONE : flt[i*8 +: 8];
	return e;
endfunction

// Register file slices that a destination may update at a given mode
function automatic logic [8:0] write_mask(input div_types_pkg::om_e om, input logic [7:0] rd);
	if (rd >= 8'd56 && rd <= 8'd63) begin
		case (om)
			div_types_pkg::OM_APP: return 9'h001;
			div_types_pkg::OM_SUPERVISOR: return 9'h003;
			div_types_pkg::OM_HYPERVISOR: return 9'h007;
			default: return 9'h1FF;
		endcase
	end
	if (rd != 8'd0)
		return 9'h1FF;
	return 9'h000;
endfunction

`endif

// ==== tb/tb_idiv_simd.sv ====
// SIMD divider testbench
`timescale 1ns/1ps
`default_nettype none

module tb_idiv_simd;

	localparam int N_DIRECTED = 17;
	localparam int N_RANDOM = 12;
	localparam int N_ROWS = N_DIRECTED + N_RANDOM;
	// Longest division is 65 cycles and a row gets a few more for load and sampling
	localparam int ROW_LIMIT = 70;
	localparam int MAX_CYCLES = 10 + N_ROWS * (ROW_LIMIT + 4) + 50;

	typedef struct {
		div_instr_pkg::opcode_e op;
		logic rem;
		div_types_pkg::prec_e prc;
		div_types_pkg::om_e om;
		logic [7:0] rd;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] t;
		logic [7:0] cp;
		logic z;
	} row_t;

	logic clk;
	logic rst;
	logic ld_i;
	div_instr_pkg::instr_t ir_i;
	div_types_pkg::prec_e prc_i;
	div_types_pkg::om_e om_i;
	logic [7:0] rd_i;
	logic [63:0] a_i;
	logic [63:0] b_i;
	logic [63:0] t_i;
	logic [7:0] cptgt_i;
	logic z_i;
	logic [63:0] o_o;
	logic [63:0] exc_o;
	logic div_done_o;
	logic div_dbz_o;
	logic [8:0] we_o;

	row_t rows[$];
	logic [31:0] lfsr_state;
	int row_errs;
	int total_errs = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycle_count = 0;

	`include "div_model.svh"

	idiv_simd i_idiv_simd (
		.clk(clk),
		.rst(rst),
		.ld_i(ld_i),
		.ir_i(ir_i),
		.prc_i(prc_i),
		.om_i(om_i),
		.rd_i(rd_i),
		.a_i(a_i),
		.b_i(b_i),
		.t_i(t_i),
		.cptgt_i(cptgt_i),
		.z_i(z_i),
		.o_o(o_o),
		.exc_o(exc_o),
		.div_done_o(div_done_o),
		.div_dbz_o(div_dbz_o),
		.we_o(we_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Watchdog over the whole run
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: simulation ran past %0d cycles", MAX_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// ======================================================================
	// Stimulus table
	// ======================================================================

	// Galois form with the taps of a maximal length 32-bit polynomial
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// One LFSR step per bit handed out
	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic add_row(input div_instr_pkg::opcode_e op, input logic rem,
			input div_types_pkg::prec_e prc, input div_types_pkg::om_e om,
			input logic [7:0] rd, input logic [63:0] a, input logic [63:0] b,
			input logic [63:0] t, input logic [7:0] cp, input logic z);
		row_t r;
		r.op = op;
		r.rem = rem;
		r.prc = prc;
		r.om = om;
		r.rd = rd;
		r.a = a;
		r.b = b;
		r.t = t;
		r.cp = cp;
		r.z = z;
		rows.push_back(r);
	endtask

	task automatic add_random_row();
		logic [63:0] v;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] t;
		logic [63:0] c1;
		logic [63:0] c2;
		div_instr_pkg::opcode_e op;
		logic rem;
		div_types_pkg::prec_e prc;
		div_types_pkg::om_e om;
		logic [7:0] rd;
		logic z;
		take_bits(1, v);
		op = v[0] ? div_instr_pkg::OP_DIV : div_instr_pkg::OP_DIVU;
		take_bits(1, v);
		rem = v[0];
		take_bits(2, v);
		prc = div_types_pkg::prec_e'(v[1:0]);
		take_bits(2, v);
		om = div_types_pkg::om_e'(v[1:0]);
		take_bits(8, v);
		rd = v[7:0];
		take_bits(64, a);
		take_bits(64, b);
		// Shorter divisors give quotients with more set bits
		take_bits(6, v);
		b = b >> v[5:0];
		take_bits(64, t);
		// Sparse copy mask so most bytes still carry the result
		take_bits(8, c1);
		take_bits(8, c2);
		take_bits(1, v);
		z = v[0];
		add_row(op, rem, prc, om, rd, a, b, t, c1[7:0] & c2[7:0], z);
	endtask

	// ======================================================================
	// Checking
	// ======================================================================

	task automatic report_mismatch(input int idx, input string what, input logic [63:0] got,
			input logic [63:0] exp);
		$display("** Error at %0t: test %0d %s is %h, expected %h", $time, idx, what, got, exp);
		row_errs++;
	endtask

	task automatic run_row(input int idx);
		row_t r;
		int cycles;
		int exp_cycles;
		logic done_seen;
		logic nop;
		logic [63:0] exp_o;
		logic [63:0] exp_exc;
		logic [8:0] exp_we;
		r = rows[idx];
		row_errs = 0;
		nop = r.op == div_instr_pkg::OP_NOP;
		exp_o = merge_word(word_result(r.a, r.b, r.prc, r.op == div_instr_pkg::OP_DIV, r.rem),
			r.t, r.cp, r.z, nop);
		exp_exc = merge_faults(word_faults(r.b, r.prc), r.cp, nop);
		exp_we = write_mask(r.om, r.rd);
		exp_cycles = lane_width(r.prc) + 1;

		@(posedge clk);
		#1;
		ir_i = '0;
		ir_i.div.opcode = r.op;
		ir_i.div.rem = r.rem;
		ir_i.div.rd = r.rd[5:0];
		prc_i = r.prc;
		om_i = r.om;
		rd_i = r.rd;
		a_i = r.a;
		b_i = r.b;
		t_i = r.t;
		cptgt_i = r.cp;
		z_i = r.z;
		ld_i = 1'b1;

		// Done and write enable both drop while the load strobe is up
		@(negedge clk);
		if (div_done_o !== 1'b0)
			report_mismatch(idx, "div_done_o during ld_i", 64'(div_done_o), 64'd0);
		if (we_o !== 9'h000)
			report_mismatch(idx, "we_o during ld_i", 64'(we_o), 64'd0);

		// Scramble every input after the load edge since the unit must hold its copy
		@(posedge clk);
		#1;
		ld_i = 1'b0;
		ir_i.div.rem = ~ir_i.div.rem;
		prc_i = div_types_pkg::prec_e'(~prc_i);
		om_i = div_types_pkg::om_e'(~om_i);
		rd_i = ~rd_i;
		a_i = ~a_i;
		b_i = ~b_i;
		t_i = ~t_i;
		cptgt_i = ~cptgt_i;
		z_i = ~z_i;

		cycles = 0;
		done_seen = 1'b0;
		while (!done_seen && cycles < ROW_LIMIT) begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
			if (div_done_o)
				done_seen = 1'b1;
		end

		if (!done_seen) begin
			$display("Test %0d timed out waiting for div_done_o after %0d cycles", idx, cycles);
			row_errs++;
		end else begin
			if (cycles != exp_cycles)
				report_mismatch(idx, "done latency", 64'(cycles), 64'(exp_cycles));
			if (o_o !== exp_o)
				report_mismatch(idx, "o_o", o_o, exp_o);
			if (exc_o !== exp_exc)
				report_mismatch(idx, "exc_o", exc_o, exp_exc);
			if (div_dbz_o !== |exp_exc)
				report_mismatch(idx, "div_dbz_o", 64'(div_dbz_o), 64'(|exp_exc));
			if (we_o !== exp_we)
				report_mismatch(idx, "we_o", 64'(we_o), 64'(exp_we));
		end

		if (row_errs == 0) begin
			$display("Test %0d ok", idx);
			tests_passed++;
		end else begin
			$display("Test %0d failed with %0d mismatches", idx, row_errs);
			tests_failed++;
		end
		total_errs += row_errs;
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		rst = 1'b1;
		ld_i = 1'b0;
		ir_i = '0;
		prc_i = div_types_pkg::WYDE;
		om_i = div_types_pkg::OM_APP;
		rd_i = 8'd0;
		a_i = '0;
		b_i = '0;
		t_i = '0;
		cptgt_i = '0;
		z_i = 1'b0;
		lfsr_state = 32'hd15a;

		// Wyde lanes mix negative values and the minimum by minus one
		add_row(div_instr_pkg::OP_DIV, 1'b0, div_types_pkg::WYDE, div_types_pkg::OM_APP, 8'd56,
			64'hFFF9_0064_8000_0007, 64'h0002_FFF7_FFFF_FFFD, 64'h1111_2222_3333_4444, 8'h00, 1'b0);
		add_row(div_instr_pkg::OP_DIV, 1'b1, div_types_pkg::WYDE,
			div_types_pkg::OM_SUPERVISOR, 8'd60,
			64'hFFF9_0064_8000_0007, 64'h0002_FFF7_FFFF_FFFD, 64'h1111_2222_3333_4444, 8'h00, 1'b0);
		add_row(div_instr_pkg::OP_DIVU, 1'b0, div_types_pkg::WYDE,
			div_types_pkg::OM_HYPERVISOR, 8'd63,
			64'hFFF9_0064_8000_0007, 64'h0002_FFF7_FFFF_FFFD, 64'h1111_2222_3333_4444, 8'h00, 1'b0);
		add_row(div_instr_pkg::OP_DIVU, 1'b1, div_types_pkg::WYDE, div_types_pkg::OM_SECURE, 8'd57,
			64'hFFF9_0064_8000_0007, 64'h0002_FFF7_FFFF_FFFD, 64'h1111_2222_3333_4444, 8'h00, 1'b0);
		// Tetra lanes, register zero and a low register for the write mask
		add_row(div_instr_pkg::OP_DIV, 1'b0, div_types_pkg::TETRA, div_types_pkg::OM_APP, 8'd0,
			64'hFFFF_FF85_7FFF_FFFF, 64'h0000_000A_FFFF_FFF0, 64'h5555_6666_7777_8888, 8'h00, 1'b0);
		add_row(div_instr_pkg::OP_DIV, 1'b1, div_types_pkg::TETRA,
			div_types_pkg::OM_SUPERVISOR, 8'd12,
			64'hFFFF_FF85_7FFF_FFFF, 64'h0000_000A_FFFF_FFF0, 64'h5555_6666_7777_8888, 8'h00, 1'b0);
		add_row(div_instr_pkg::OP_DIVU, 1'b0, div_types_pkg::TETRA, div_types_pkg::OM_APP, 8'd30,
			64'hFFFF_FF85_7FFF_FFFF, 64'h0000_000A_FFFF_FFF0, 64'h5555_6666_7777_8888, 8'h00, 1'b0);
		add_row(div_instr_pkg::OP_DIVU, 1'b1, div_types_pkg::TETRA,
			div_types_pkg::OM_HYPERVISOR, 8'd59,
			64'hFFFF_FF85_7FFF_FFFF, 64'h0000_000A_FFFF_FFF0, 64'h5555_6666_7777_8888, 8'h00, 1'b0);
		// Octa lane, then the spare precision code
		add_row(div_instr_pkg::OP_DIV, 1'b0, div_types_pkg::OCTA, div_types_pkg::OM_SECURE, 8'd62,
			64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'h9999_AAAA_BBBB_CCCC, 8'h00, 1'b0);
		add_row(div_instr_pkg::OP_DIV, 1'b1, div_types_pkg::OCTA, div_types_pkg::OM_APP, 8'd58,
			64'hFFFF_FFFF_FFFF_FC19, 64'd37, 64'h9999_AAAA_BBBB_CCCC, 8'h00, 1'b0);
		add_row(div_instr_pkg::OP_DIVU, 1'b1, div_types_pkg::OCTA,
			div_types_pkg::OM_HYPERVISOR, 8'd5,
			64'hFFFF_FFFF_FFFF_FC19, 64'd37, 64'h9999_AAAA_BBBB_CCCC, 8'h00, 1'b0);
		add_row(div_instr_pkg::OP_DIVU, 1'b0, div_types_pkg::prec_e'(2'd3),
			div_types_pkg::OM_SUPERVISOR, 8'd200,
			64'hFEDC_BA98_7654_3210, 64'h0000_0000_0012_3457, 64'h0, 8'h00, 1'b0);
		// Divide by zero in a single lane
		add_row(div_instr_pkg::OP_DIV, 1'b0, div_types_pkg::WYDE,
			div_types_pkg::OM_HYPERVISOR, 8'd61,
			64'h1234_8765_4321_0FFF, 64'h0003_0000_FFFE_0010, 64'h0, 8'h00, 1'b0);
		add_row(div_instr_pkg::OP_DIVU, 1'b1, div_types_pkg::TETRA, div_types_pkg::OM_SECURE, 8'd56,
			64'hDEAD_BEEF_0000_1000, 64'h0000_0000_0000_0007, 64'h0, 8'h00, 1'b0);
		// Copy mask over the faulting lane, keeping then clearing the target
		add_row(div_instr_pkg::OP_DIV, 1'b0, div_types_pkg::WYDE, div_types_pkg::OM_APP, 8'd63,
			64'h1234_8765_4321_0FFF, 64'h0003_0000_FFFE_0010, 64'hA5A5_5A5A_C3C3_3C3C, 8'h3C, 1'b0);
		add_row(div_instr_pkg::OP_DIV, 1'b0, div_types_pkg::WYDE,
			div_types_pkg::OM_SUPERVISOR, 8'd1,
			64'h1234_8765_4321_0FFF, 64'h0003_0000_FFFE_0010, 64'hA5A5_5A5A_C3C3_3C3C, 8'hF0, 1'b1);
		// NOP with every divisor zero still returns the target without faults
		add_row(div_instr_pkg::OP_NOP, 1'b0, div_types_pkg::WYDE, div_types_pkg::OM_SECURE, 8'd60,
			64'h1357_9BDF_2468_ACE0, 64'h0, 64'h0123_4567_89AB_CDEF, 8'h00, 1'b0);
		for (int i = 0; i < N_RANDOM; i++)
			add_random_row();

		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		// Idle state straight out of reset
		row_errs = 0;
		@(negedge clk);
		if (div_done_o !== 1'b1)
			report_mismatch(-1, "div_done_o after reset", 64'(div_done_o), 64'd1);
		if (we_o !== 9'h000)
			report_mismatch(-1, "we_o after reset", 64'(we_o), 64'd0);
		if (row_errs == 0) begin
			$display("Reset test ok");
			tests_passed++;
		end else begin
			$display("Reset test failed with %0d mismatches", row_errs);
			tests_failed++;
		end
		total_errs += row_errs;

		for (int i = 0; i < rows.size(); i++)
			run_row(i);

		$display("Tests passed %0d, failed %0d, mismatches %0d",
			tests_passed, tests_failed, total_errs);
		if (tests_failed == 0 && total_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== idiv/idiv_simd.sv ====
// SIMD integer divide unit
`timescale 1ns/1ps
`default_nettype none

module idiv_simd (
	input wire clk,
	input wire rst,
	input wire ld_i,
	input wire div_instr_pkg::instr_t ir_i,
	input wire div_types_pkg::prec_e prc_i,
	input wire div_types_pkg::om_e om_i,
	input wire [div_types_pkg::RD_W-1:0] rd_i,
	input wire [div_types_pkg::DATA_W-1:0] a_i,
	input wire [div_types_pkg::DATA_W-1:0] b_i,
	input wire [div_types_pkg::DATA_W-1:0] t_i,
	input wire [div_types_pkg::NBYTES-1:0] cptgt_i,
	input wire z_i,
	output logic [div_types_pkg::DATA_W-1:0] o_o,
	output logic [div_types_pkg::DATA_W-1:0] exc_o,
	output logic div_done_o,
	output logic div_dbz_o,
	output logic [div_types_pkg::WE_W-1:0] we_o
);

	// Per group result, fault word and lane done levels
	// Group 0 is wyde, 1 is tetra, 2 is octa
	wire [div_types_pkg::DATA_W-1:0] res_g [div_types_pkg::NGRP];
	wire [div_types_pkg::DATA_W-1:0] exc_g [div_types_pkg::NGRP];
	wire [div_types_pkg::NLANE_MAX-1:0] done_g [div_types_pkg::NGRP];

	div_types_pkg::prec_e prc_r;
	logic [1:0] grp_sel;
	logic [div_types_pkg::DATA_W-1:0] res_sel;
	logic [div_types_pkg::DATA_W-1:0] exc_sel;
	logic grp_done;
	logic ld_seen_r;
	logic res_vld;
	logic [div_types_pkg::WE_W-1:0] we_r;

	// ======================================================================
	// Lane groups
	// ======================================================================

	// Every group runs on every load and the precision only picks the output
	for (genvar k = 0; k < div_types_pkg::NGRP; k++) begin : g_grp
		localparam int LW = div_types_pkg::LANE_MIN_W << k;
		localparam int NL = div_types_pkg::DATA_W / LW;

		for (genvar l = 0; l < NL; l++) begin : g_lane
			idiv_lane #(
				.W(LW)
			) u_lane (
				.clk(clk),
				.rst(rst),
				.ld_i(ld_i),
				.ir_i(ir_i),
				.a_i(a_i[l*LW +: LW]),
				.b_i(b_i[l*LW +: LW]),
				.res_o(res_g[k][l*LW +: LW]),
				.done_o(done_g[k][l]),
				.flt_o(exc_g[k][l*LW +: div_types_pkg::FLT_W])
			);

			// Fault code sits in the low byte of the lane and the rest reads zero
			assign exc_g[k][l*LW+div_types_pkg::FLT_W +: LW-div_types_pkg::FLT_W] = '0;
		end

		// Groups with fewer lanes tie the spare done bits high for the AND
		if (NL < div_types_pkg::NLANE_MAX) begin : g_pad
			assign done_g[k][div_types_pkg::NLANE_MAX-1:NL] = '1;
		end
	end

	// ======================================================================
	// Group selection
	// ======================================================================

	// Precision is held from the load so the caller may change it
	always_ff @(posedge clk) begin
		if (rst)
			prc_r <= div_types_pkg::OCTA;
		else if (ld_i)
			prc_r <= prc_i;
	end

	always_comb begin
		case (prc_r)
			div_types_pkg::WYDE: grp_sel = 2'd0;
			div_types_pkg::TETRA: grp_sel = 2'd1;
			// Octa and the unused code both land on the single wide lane
			default: grp_sel = 2'd2;
		endcase
		res_sel = res_g[grp_sel];
		exc_sel = exc_g[grp_sel];
		// A group is finished only when all of its lanes are
		grp_done = &done_g[grp_sel];
	end

	// Target merge and fault squash
	lane_merge u_merge (
		.clk(clk),
		.rst(rst),
		.ld_i(ld_i),
		.ir_i(ir_i),
		.t_i(t_i),
		.z_i(z_i),
		.cptgt_i(cptgt_i),
		.res_i(res_sel),
		.flt_i(exc_sel),
		.o_o(o_o),
		.exc_o(exc_o)
	);

	// ======================================================================
	// Status and write mask
	// ======================================================================

	// Results only count once a load has been taken since reset
	always_ff @(posedge clk) begin
		if (rst)
			ld_seen_r <= 1'b0;
		else if (ld_i)
			ld_seen_r <= 1'b1;
	end

	assign res_vld = ld_seen_r & grp_done;

	// Idle after reset since all lanes come up done
	assign div_done_o = ~ld_i & grp_done;
	assign div_dbz_o = |exc_o;

	// Which register file slices the result may update
	always_ff @(posedge clk) begin
		if (rst) begin
			we_r <= '0;
		end else if (ld_i) begin
			if (rd_i >= 8'd56 && rd_i <= 8'd63) begin
				// Upper registers are banked by privilege level
				case (om_i)
					div_types_pkg::OM_APP: we_r <= 9'h001;
					div_types_pkg::OM_SUPERVISOR: we_r <= 9'h003;
					div_types_pkg::OM_HYPERVISOR: we_r <= 9'h007;
					default: we_r <= 9'h1FF;
				endcase
			end else if (|rd_i) begin
				we_r <= 9'h1FF;
			end else begin
				// Register zero is never written
				we_r <= 9'h000;
			end
		end
	end

	assign we_o = (res_vld && !ld_i) ? we_r : '0;

endmodule

`default_nettype wire

// ==== logic/lane_merge.sv ====
// Byte merge with target
`timescale 1ns/1ps
`default_nettype none

module lane_merge (
	input wire clk,
	input wire rst,
	input wire ld_i,
	input wire div_instr_pkg::instr_t ir_i,
	input wire [div_types_pkg::DATA_W-1:0] t_i,
	input wire z_i,
	input wire [div_types_pkg::NBYTES-1:0] cptgt_i,
	input wire [div_types_pkg::DATA_W-1:0] res_i,
	input wire [div_types_pkg::DATA_W-1:0] flt_i,
	output logic [div_types_pkg::DATA_W-1:0] o_o,
	output logic [div_types_pkg::DATA_W-1:0] exc_o
);

	localparam int BW = div_types_pkg::BYTE_W;

	// Context captured alongside the load
	logic [div_types_pkg::DATA_W-1:0] t_r;
	logic z_r;
	logic [div_types_pkg::NBYTES-1:0] cp_r;
	div_instr_pkg::opcode_e op_r;
	logic nop;

	always_ff @(posedge clk) begin
		if (rst) begin
			op_r <= div_instr_pkg::OP_NOP;
			cp_r <= '0;
			z_r <= 1'b0;
		end else if (ld_i) begin
			// Generic view is enough to spot a NOP
			op_r <= ir_i.any.opcode;
			cp_r <= cptgt_i;
			z_r <= z_i;
		end
	end

	always_ff @(posedge clk) begin
		if (ld_i)
			t_r <= t_i;
	end

	assign nop = op_r == div_instr_pkg::OP_NOP;

	// ======================================================================
	// Per byte select
	// ======================================================================

	always_comb begin
		for (int i = 0; i < div_types_pkg::NBYTES; i++) begin
			// NOP leaves the whole target as is
			if (nop)
				o_o[i*BW +: BW] = t_r[i*BW +: BW];
			// Copied bytes keep the target or clear it
			else if (cp_r[i])
				o_o[i*BW +: BW] = z_r ? '0 : t_r[i*BW +: BW];
			else
				o_o[i*BW +: BW] = res_i[i*BW +: BW];

			// Bytes that do not take the result cannot raise a fault
			if (nop || cp_r[i])
				exc_o[i*BW +: BW] = div_types_pkg::FLT_NONE;
			else
				exc_o[i*BW +: BW] = flt_i[i*BW +: BW];
		end
	end

endmodule

`default_nettype wire

// ==== idiv/idiv_lane.sv ====
// Restoring divider lane
`timescale 1ns/1ps
`default_nettype none

module idiv_lane #(
	parameter int W = 16
) (
	input wire clk,
	input wire rst,
	input wire ld_i,
	input wire div_instr_pkg::instr_t ir_i,
	input wire [W-1:0] a_i,
	input wire [W-1:0] b_i,
	output logic [W-1:0] res_o,
	output logic done_o,
	output logic [div_types_pkg::FLT_W-1:0] flt_o
);

	// Counter must be able to hold the value W itself
	localparam int CW = $clog2(W + 1);

	// Quotient shifts in from the right while the dividend shifts out
	logic [W-1:0] q_r;
	logic [W-1:0] r_r;
	logic [W-1:0] d_r;
	logic [CW-1:0] cnt_r;
	logic busy_r;
	logic rem_r;
	logic neg_q_r;
	logic neg_r_r;
	logic dbz_r;

	logic sgn;
	logic neg_a;
	logic neg_b;
	logic [W-1:0] mag_a;
	logic [W-1:0] mag_b;
	logic [W:0] r_sh;
	logic [W:0] diff;
	logic fit;
	logic last;
	logic [W-1:0] q_fin;
	logic [W-1:0] r_fin;

	// ======================================================================
	// Operand conditioning and one restoring step
	// ======================================================================

	always_comb begin
		// Only the signed opcode treats the top bit as a sign
		sgn = ir_i.div.opcode == div_instr_pkg::OP_DIV;
		neg_a = sgn & a_i[W-1];
		neg_b = sgn & b_i[W-1];
		mag_a = neg_a ? -a_i : a_i;
		mag_b = neg_b ? -b_i : b_i;

		// Partial remainder picks up the next dividend bit
		r_sh = {r_r, q_r[W-1]};
		diff = r_sh - {1'b0, d_r};
		// Compare rather than borrow so a zero divisor still subtracts cleanly
		fit = r_sh >= {1'b0, d_r};
		last = cnt_r == CW'(W);

		// Truncation toward zero, remainder follows the dividend sign
		q_fin = neg_q_r ? -q_r : q_r;
		r_fin = neg_r_r ? -r_r : r_r;
	end

	// ======================================================================
	// Sequencing
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_r <= 1'b0;
			done_o <= 1'b1;
			cnt_r <= '0;
			rem_r <= 1'b0;
			neg_q_r <= 1'b0;
			neg_r_r <= 1'b0;
			dbz_r <= 1'b0;
			res_o <= '0;
			flt_o <= div_types_pkg::FLT_NONE;
		end else if (ld_i) begin
			// A load always restarts, even in the middle of a division
			busy_r <= 1'b1;
			done_o <= 1'b0;
			cnt_r <= '0;
			rem_r <= ir_i.div.rem;
			neg_q_r <= neg_a ^ neg_b;
			neg_r_r <= neg_a;
			dbz_r <= b_i == '0;
		end else if (busy_r) begin
			if (last) begin
				busy_r <= 1'b0;
				done_o <= 1'b1;
				// Divide by zero forces an all ones quotient
				// The remainder already equals the dividend in that case
				if (rem_r)
					res_o <= r_fin;
				else if (dbz_r)
					res_o <= '1;
				else
					res_o <= q_fin;
				flt_o <= dbz_r ? div_types_pkg::FLT_DBZ : div_types_pkg::FLT_NONE;
			end else begin
				cnt_r <= cnt_r + 1'b1;
			end
		end
	end

	// Shift registers of the restoring loop
	always_ff @(posedge clk) begin
		if (ld_i) begin
			q_r <= mag_a;
			r_r <= '0;
			d_r <= mag_b;
		end else if (busy_r && !last) begin
			r_r <= fit ? diff[W-1:0] : r_sh[W-1:0];
			q_r <= {q_r[W-2:0], fit};
		end
	end

endmodule

`default_nettype wire

// ==== common/div_instr_pkg.sv ====
// Divider instruction format
`default_nettype none

package div_instr_pkg;

	// Major opcodes handled by the divide unit
	// NOP passes the target through untouched
	typedef enum logic [6:0] {
		OP_NOP  = 7'h00,
		OP_DIV  = 7'h1C,
		OP_DIVU = 7'h1D
	} opcode_e;

	// Generic view where only the opcode is meaningful
	typedef struct packed {
		logic [24:0] payload;
		opcode_e opcode;
	} any_instr_t;

	// Divide format
	// The rem bit selects remainder instead of quotient
	typedef struct packed {
		logic [5:0] spare;
		logic [5:0] rs2;
		logic [5:0] rs1;
		logic [5:0] rd;
		logic rem;
		opcode_e opcode;
	} div_instr_t;

	// Both views overlay the same 32-bit instruction word
	typedef union packed {
		any_instr_t any;
		div_instr_t div;
	} instr_t;

endpackage

`default_nettype wire

// ==== common/div_types_pkg.sv ====
// Divider datapath types
`default_nettype none

package div_types_pkg;

	// ======================================================================
	// Datapath geometry
	// ======================================================================

	// One machine word is carried on every data port
	localparam int DATA_W = 64;

	// Byte granularity of the copy mask and of the fault word
	localparam int BYTE_W = 8;
	localparam int NBYTES = DATA_W / BYTE_W;

	// Narrowest lane is a wyde, so at most four lanes share a word
	localparam int LANE_MIN_W = 16;
	localparam int NLANE_MAX = DATA_W / LANE_MIN_W;

	// Wyde, tetra and octa lane groups
	localparam int NGRP = 3;

	// Destination register number and register file write mask widths
	localparam int RD_W = 8;
	localparam int WE_W = NBYTES + 1;

	// ======================================================================
	// Control encodings
	// ======================================================================

	// Lane precision of the operation
	// The spare encoding is treated as a single octa lane
	typedef enum logic [1:0] {
		WYDE  = 2'd0,
		TETRA = 2'd1,
		OCTA  = 2'd2
	} prec_e;

	// Privilege level the instruction was issued at
	typedef enum logic [1:0] {
		OM_APP        = 2'd0,
		OM_SUPERVISOR = 2'd1,
		OM_HYPERVISOR = 2'd2,
		OM_SECURE     = 2'd3
	} om_e;

	// Fault codes reported per lane, one byte each
	localparam int FLT_W = 8;
	localparam logic [FLT_W-1:0] FLT_NONE = 8'h00;
	localparam logic [FLT_W-1:0] FLT_DBZ = 8'h22;

endpackage

`default_nettype wire
